// File: vlog.f
+incdir+verif
hw/bus_pkg.sv
hw/mem_map_pkg.sv
hw/mmio_ctrl.sv
hw/rtc_counter.sv
hw/data_ram.sv
hw/kbd_fifo.sv
hw/mmio.sv
hw/mmio_top.sv
verif/mmio_tb.sv

// File: run_verilator.sh
#!/bin/sh
# build the mmio testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module mmio_tb \
    -Mdir obj_dir \
    -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vmmio_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0

// File: verif/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// device a row is aimed at
typedef enum logic [2:0] {T_RAM, T_KBD, T_SWT, T_SEG, T_LED, T_SER, T_NONE} tgt_e;

typedef struct packed {
    logic   write;
    addr_t  addr;
    width_e width;
    tgt_e   target;
    // wdata replaced by a random doubleword
    logic   rnd;
    data_t  wdata;
    logic   exp_err;
} vec_t;

localparam int NUM_VECS = 26;

// one request per row with write, address, width, target, random data,
// write data and expected err
// read data comes from the reference state
localparam vec_t VECS [NUM_VECS] = '{
    '{1'b0, 32'hA000_0060, WIDTH_DOUBLE, T_KBD,  1'b0, 64'h0,                   1'b0},
    '{1'b1, 32'h8000_0000, WIDTH_DOUBLE, T_RAM,  1'b1, 64'h0,                   1'b0},
    '{1'b1, 32'h8000_0008, WIDTH_DOUBLE, T_RAM,  1'b1, 64'h0,                   1'b0},
    '{1'b1, 32'h8000_0FF8, WIDTH_DOUBLE, T_RAM,  1'b1, 64'h0,                   1'b0},
    '{1'b0, 32'h8000_0000, WIDTH_DOUBLE, T_RAM,  1'b0, 64'h0,                   1'b0},
    '{1'b0, 32'h8000_0008, WIDTH_DOUBLE, T_RAM,  1'b0, 64'h0,                   1'b0},
    '{1'b0, 32'h8000_0FF8, WIDTH_DOUBLE, T_RAM,  1'b0, 64'h0,                   1'b0},
    '{1'b1, 32'h8000_0003, WIDTH_BYTE,   T_RAM,  1'b0, 64'h0000_0000_0000_00A5, 1'b0},
    '{1'b1, 32'h8000_0006, WIDTH_HALF,   T_RAM,  1'b0, 64'h0000_0000_0000_BEEF, 1'b0},
    '{1'b1, 32'h8000_000C, WIDTH_WORD,   T_RAM,  1'b0, 64'h0000_0000_1234_5678, 1'b0},
    '{1'b1, 32'h8000_0FFF, WIDTH_BYTE,   T_RAM,  1'b0, 64'hFFFF_FFFF_FFFF_FF5A, 1'b0},
    '{1'b1, 32'h8000_0FFA, WIDTH_HALF,   T_RAM,  1'b1, 64'h0,                   1'b0},
    '{1'b0, 32'h8000_0000, WIDTH_DOUBLE, T_RAM,  1'b0, 64'h0,                   1'b0},
    '{1'b0, 32'h8000_0008, WIDTH_DOUBLE, T_RAM,  1'b0, 64'h0,                   1'b0},
    '{1'b0, 32'h8000_0FF8, WIDTH_DOUBLE, T_RAM,  1'b0, 64'h0,                   1'b0},
    '{1'b1, 32'hA000_0200, WIDTH_WORD,   T_SEG,  1'b0, 64'h1111_2222_DEAD_BEEF, 1'b0},
    '{1'b1, 32'hA000_0208, WIDTH_HALF,   T_LED,  1'b0, 64'h3333_4444_5555_C3A5, 1'b0},
    '{1'b0, 32'hA000_0200, WIDTH_DOUBLE, T_SEG,  1'b0, 64'h0,                   1'b0},
    '{1'b1, 32'hA000_03F8, WIDTH_BYTE,   T_SER,  1'b0, 64'h0000_0000_0000_7E41, 1'b0},
    '{1'b0, 32'hA000_0100, WIDTH_DOUBLE, T_SWT,  1'b0, 64'h0,                   1'b0},
    '{1'b0, 32'hA000_0104, WIDTH_DOUBLE, T_SWT,  1'b0, 64'h0,                   1'b0},
    '{1'b1, 32'h8000_1000, WIDTH_DOUBLE, T_NONE, 1'b1, 64'h0,                   1'b1},
    '{1'b0, 32'hA000_0000, WIDTH_DOUBLE, T_NONE, 1'b0, 64'h0,                   1'b1},
    '{1'b1, 32'hA000_0210, WIDTH_DOUBLE, T_NONE, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1},
    '{1'b0, 32'h8000_0000, WIDTH_DOUBLE, T_RAM,  1'b0, 64'h0,                   1'b0},
    '{1'b0, 32'h8000_0FF8, WIDTH_DOUBLE, T_RAM,  1'b0, 64'h0,                   1'b0}
};

`endif

// File: verif/mmio_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_tb;

    import bus_pkg::*;

    localparam int RAM_WORDS    = 512;
    localparam int KB_DEPTH     = 8;
    localparam int CLK_DIV      = 4;
    localparam int TIMEOUT      = 20;
    localparam int RESP_LATENCY = 2;

    `include "tb_vectors.svh"

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    bus_req_t   req;
    logic       resp_valid;
    logic       resp_ready;
    bus_resp_t  resp;
    logic       kb_valid;
    logic       kb_ready;
    kb_code_t   kb_code;
    logic [7:0] swt;
    seg_t       seg;
    led_t       led;
    logic       serial_valid;
    logic [7:0] serial_byte;

    // reference state
    data_t      ram_model [RAM_WORDS];
    seg_t       seg_model;
    led_t       led_model;
    kb_code_t   kbd_model [$];
    int         serial_count;
    logic [7:0] serial_last;

    mmio_top #(
        .RAM_WORDS (RAM_WORDS),
        .KB_DEPTH  (KB_DEPTH),
        .CLK_DIV   (CLK_DIV)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp),
        .kb_valid     (kb_valid),
        .kb_ready     (kb_ready),
        .kb_code      (kb_code),
        .swt          (swt),
        .seg          (seg),
        .led          (led),
        .serial_valid (serial_valid),
        .serial_byte  (serial_byte)
    );

    always #5 clk = ~clk;

    // serial pulses seen during the current access
    always @(negedge clk) begin
        if (serial_valid) begin
            serial_count = serial_count + 1;
            serial_last  = serial_byte;
        end
    end

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_error(input string why);
        $display("ERROR: %s", why);
        stop_run();
    endtask

    task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got rdata=%h err=%h, expected rdata=%h err=%h",
                     name, got.rdata, got.err, exp.rdata, exp.err);
            stop_run();
        end
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_led(input string name, input led_t got, input led_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic bus_req_t make_req(logic write, addr_t addr, width_e width, data_t wdata);
        bus_req_t r;
        r.write = write;
        r.addr  = addr;
        r.width = width;
        r.wdata = wdata;
        return r;
    endfunction

    // bytes from the offset upward, clipped at the doubleword
    function automatic data_t merge_bytes(data_t old, data_t wdata, width_e width,
                                          logic [2:0] offs);
        data_t res;
        int    nbytes;
        res = old;
        case (width)
            WIDTH_BYTE: nbytes = 1;
            WIDTH_HALF: nbytes = 2;
            WIDTH_WORD: nbytes = 4;
            default:    nbytes = 8;
        endcase
        for (int b = 0; b < 8; b++) begin
            if (b >= int'(offs) && b < int'(offs) + nbytes) begin
                res[b*8 +: 8] = wdata[(b - int'(offs))*8 +: 8];
            end
        end
        return res;
    endfunction

    // one request, hold = cycles with resp_ready low after resp_valid
    task automatic bus_access(input bus_req_t r, input int hold, output bus_resp_t got);
        int waited;
        int lat;
        serial_count = 0;
        resp_ready   = (hold == 0);
        req          = r;
        req_valid    = 1'b1;
        waited       = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_error("timeout waiting for req_ready");
            end
            @(negedge clk);
        end
        // accepting edge
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat       = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT) begin
                report_error("timeout waiting for resp_valid");
            end
        end while (!resp_valid);
        if (lat != RESP_LATENCY) begin
            report_error($sformatf("resp_valid came %0d cycles after acceptance, not %0d",
                                   lat, RESP_LATENCY));
        end
        got = resp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_resp("resp while stalled", resp, got);
            if (!resp_valid || req_ready) begin
                report_error("handshake moved while resp_ready was low");
            end
        end
        if (hold > 0) begin
            @(posedge clk);
            #1;
            resp_ready = 1'b1;
        end
        // response taken, then one cycle more to close the serial window
        @(posedge clk);
        @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic push_code(input kb_code_t code);
        int waited;
        kb_code  = code;
        kb_valid = 1'b1;
        waited   = 0;
        @(negedge clk);
        while (!kb_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_error("timeout waiting for kb_ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        kb_valid = 1'b0;
        kbd_model.push_back(code);
    endtask

    task automatic apply_table();
        vec_t      v;
        data_t     wd;
        bus_resp_t exp;
        bus_resp_t got;
        int        idx;
        for (int i = 0; i < NUM_VECS; i++) begin
            v   = VECS[i];
            wd  = v.rnd ? {$urandom, $urandom} : v.wdata;
            swt = 8'($urandom);
            idx = int'((v.addr >> 3) % RAM_WORDS);
            exp.err   = v.exp_err;
            exp.rdata = '0;
            if (!v.write && v.target == T_RAM) begin
                exp.rdata = ram_model[idx];
            end
            if (!v.write && v.target == T_SWT) begin
                exp.rdata = {56'h0, swt};
            end
            if (!v.write && v.target == T_KBD && kbd_model.size() > 0) begin
                exp.rdata = {56'h0, kbd_model.pop_front()};
            end
            bus_access(make_req(v.write, v.addr, v.width, wd), 0, got);
            check_resp($sformatf("resp of row %0d", i), got, exp);
            if (v.write && v.target == T_RAM) begin
                ram_model[idx] = merge_bytes(ram_model[idx], wd, v.width, v.addr[2:0]);
            end
            if (v.write && v.target == T_SEG) begin
                seg_model = wd[31:0];
            end
            if (v.write && v.target == T_LED) begin
                led_model = wd[15:0];
            end
            if (v.write && v.target == T_SER) begin
                if (serial_count != 1) begin
                    report_error($sformatf("serial write gave %0d pulses", serial_count));
                end
                check_byte("serial_byte", serial_last, wd[7:0]);
            end else if (serial_count != 0) begin
                report_error("serial_valid pulsed without a serial write");
            end
            check_seg("seg", seg, seg_model);
            check_led("led", led, led_model);
        end
    endtask

    task automatic read_keyboard_back();
        kb_code_t  codes [3];
        bus_resp_t exp;
        bus_resp_t got;
        codes = '{8'h1C, 8'h32, 8'h21};
        foreach (codes[i]) begin
            push_code(codes[i]);
        end
        // the last read finds the FIFO drained
        for (int i = 0; i < 4; i++) begin
            exp.err   = 1'b0;
            exp.rdata = '0;
            if (kbd_model.size() > 0) begin
                exp.rdata = {56'h0, kbd_model.pop_front()};
            end
            bus_access(make_req(1'b0, 32'hA000_0060, WIDTH_DOUBLE, '0), 0, got);
            check_resp("keyboard resp", got, exp);
        end
    endtask

    task automatic read_rtc_twice();
        bus_resp_t first;
        bus_resp_t second;
        // counter keeps running while the first response is stalled
        bus_access(make_req(1'b0, 32'hA000_0048, WIDTH_DOUBLE, '0), 6, first);
        repeat (2 * CLK_DIV + 2) @(posedge clk);
        #1;
        bus_access(make_req(1'b0, 32'hA000_0048, WIDTH_DOUBLE, '0), 0, second);
        if (first.err || second.err) begin
            report_error("RTC read came back flagged as unmapped");
        end
        if (second.rdata <= first.rdata) begin
            report_error($sformatf("RTC did not advance, %h then %h",
                                   first.rdata, second.rdata));
        end
    endtask

    initial begin
        int unsigned seed_sink;
        seed_sink    = $urandom(84);
        clk          = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        resp_ready   = 1'b1;
        kb_valid     = 1'b0;
        kb_code      = '0;
        swt          = '0;
        seg_model    = '0;
        led_model    = '0;
        serial_count = 0;
        serial_last  = '0;
        repeat (5) @(posedge clk);
        #1;
        // state straight out of reset
        if (!req_ready || resp_valid || serial_valid || dut_i.kb_pop) begin
            report_error("handshake outputs wrong after reset");
        end
        if (!kb_ready || dut_i.kb_not_empty || dut_i.rtc_count != '0) begin
            report_error("FIFO or RTC not cleared by reset");
        end
        check_seg("seg", seg, '0);
        check_led("led", led, '0);
        rst = 1'b0;
        apply_table();
        read_keyboard_back();
        read_rtc_twice();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/mmio_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_top #(
    parameter int RAM_WORDS = 512,
    parameter int KB_DEPTH  = 8,
    parameter int CLK_DIV   = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    output logic               req_ready,
    input  bus_pkg::bus_req_t  req,
    output logic               resp_valid,
    input  logic               resp_ready,
    output bus_pkg::bus_resp_t resp,
    input  logic               kb_valid,
    output logic               kb_ready,
    input  bus_pkg::kb_code_t  kb_code,
    input  logic [7:0]         swt,
    output bus_pkg::seg_t      seg,
    output bus_pkg::led_t      led,
    output logic               serial_valid,
    output logic [7:0]         serial_byte
);

    import bus_pkg::*;

    bus_req_t cur_req;
    logic     access_en;
    logic     ram_hit;
    logic     kb_pop;
    logic     kb_not_empty;
    kb_code_t kb_head;
    data_t    ram_rdata;
    data_t    rtc_count;

    mmio_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .access_en  (access_en),
        .cur_req    (cur_req)
    );

    rtc_counter #(.CLK_DIV(CLK_DIV)) u_rtc (
        .clk   (clk),
        .rst   (rst),
        .count (rtc_count)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk       (clk),
        .access_en (access_en),
        .cur_req   (cur_req),
        .hit       (ram_hit),
        .rdata     (ram_rdata)
    );

    kbd_fifo #(.KB_DEPTH(KB_DEPTH)) u_kbd (
        .clk       (clk),
        .rst       (rst),
        .kb_valid  (kb_valid),
        .kb_code   (kb_code),
        .kb_ready  (kb_ready),
        .pop       (kb_pop),
        .head      (kb_head),
        .not_empty (kb_not_empty)
    );

    mmio u_mmio (
        .clk          (clk),
        .rst          (rst),
        .access_en    (access_en),
        .cur_req      (cur_req),
        .ram_rdata    (ram_rdata),
        .kb_head      (kb_head),
        .kb_not_empty (kb_not_empty),
        .swt          (swt),
        .rtc_count    (rtc_count),
        .ram_hit      (ram_hit),
        .kb_pop       (kb_pop),
        .resp         (resp),
        .seg          (seg),
        .led          (led),
        .serial_valid (serial_valid),
        .serial_byte  (serial_byte)
    );

endmodule

`default_nettype wire

// File: hw/mmio.sv
`timescale 1ns/1ps
`default_nettype none

module mmio (
    input  logic               clk,
    input  logic               rst,
    input  logic               access_en,
    input  bus_pkg::bus_req_t  cur_req,
    input  bus_pkg::data_t     ram_rdata,
    input  bus_pkg::kb_code_t  kb_head,
    input  logic               kb_not_empty,
    input  logic [7:0]         swt,
    input  bus_pkg::data_t     rtc_count,
    output logic               ram_hit,
    output logic               kb_pop,
    output bus_pkg::bus_resp_t resp,
    output bus_pkg::seg_t      seg,
    output bus_pkg::led_t      led,
    output logic               serial_valid,
    output logic [7:0]         serial_byte
);

    import bus_pkg::*;
    import mem_map_pkg::*;

    region_e region;
    data_t   rd_val;
    data_t   rdata_q;
    logic    err_q;
    logic    ram_rd_q;
    logic    wr_en;
    logic    rd_en;

    assign region  = region_of(cur_req.addr);
    assign ram_hit = (region == REGION_RAM);

    assign wr_en = access_en && cur_req.write;
    assign rd_en = access_en && !cur_req.write;

    // head leaves the FIFO on the same edge it is registered
    assign kb_pop = rd_en && (region == REGION_KBD) && kb_not_empty;

    // non-RAM read value, zero-extended
    always_comb begin
        case (region)
            REGION_KBD: rd_val = kb_not_empty ? {56'h0, kb_head} : '0;
            REGION_SWT: rd_val = {56'h0, swt};
            REGION_RTC: rd_val = rtc_count;
            default:    rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access_en) begin
            rdata_q <= cur_req.write ? '0 : rd_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            err_q    <= 1'b0;
            ram_rd_q <= 1'b0;
        end else if (access_en) begin
            err_q    <= (region == REGION_NONE);
            ram_rd_q <= ram_hit && !cur_req.write;
        end
    end

    // RAM word arrives registered from data_ram
    assign resp = '{rdata: ram_rd_q ? ram_rdata : rdata_q, err: err_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            seg          <= '0;
            led          <= '0;
            serial_valid <= 1'b0;
        end else begin
            serial_valid <= wr_en && (region == REGION_SERIAL);
            if (wr_en && region == REGION_SEG) begin
                seg <= cur_req.wdata[31:0];
            end
            if (wr_en && region == REGION_LED) begin
                led <= cur_req.wdata[15:0];
            end
        end
    end

    // byte qualified by serial_valid
    always_ff @(posedge clk) begin
        if (wr_en && region == REGION_SERIAL) begin
            serial_byte <= cur_req.wdata[7:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/kbd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_fifo #(
    parameter int KB_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              kb_valid,
    input  bus_pkg::kb_code_t kb_code,
    output logic              kb_ready,
    input  logic              pop,
    output bus_pkg::kb_code_t head,
    output logic              not_empty
);

    import bus_pkg::*;

    localparam int PTR_W = (KB_DEPTH > 1) ? $clog2(KB_DEPTH) : 1;

    kb_code_t         mem [KB_DEPTH];
    logic [PTR_W-1:0] wptr_q;
    logic [PTR_W-1:0] rptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             do_pop;

    assign kb_ready  = (count_q != (PTR_W+1)'(KB_DEPTH));
    assign not_empty = (count_q != '0);
    assign head      = mem[rptr_q];

    assign push   = kb_valid && kb_ready;
    // pop of an empty buffer is dropped
    assign do_pop = pop && not_empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr_q] <= kb_code;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= (wptr_q == PTR_W'(KB_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (do_pop) begin
                rptr_q <= (rptr_q == PTR_W'(KB_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            case ({push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 512
) (
    input  logic              clk,
    input  logic              access_en,
    input  bus_pkg::bus_req_t cur_req,
    input  logic              hit,
    output bus_pkg::data_t    rdata
);

    import bus_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    data_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [2:0]       offs;
    logic [7:0]       width_mask;
    logic [7:0]       byte_mask;
    data_t            wdata_sh;

    // doubleword index above the byte offset
    assign idx  = cur_req.addr[IDX_W+2:3];
    assign offs = cur_req.addr[2:0];

    always_comb begin
        case (cur_req.width)
            WIDTH_BYTE: width_mask = 8'h01;
            WIDTH_HALF: width_mask = 8'h03;
            WIDTH_WORD: width_mask = 8'h0F;
            default:    width_mask = 8'hFF;
        endcase
    end

    // lanes line up with the byte offset
    assign byte_mask = width_mask << offs;
    assign wdata_sh  = cur_req.wdata << {offs, 3'b000};

    always_ff @(posedge clk) begin
        if (access_en && hit) begin
            // read-first, the old word is registered
            rdata <= mem[idx];
            if (cur_req.write) begin
                for (int b = 0; b < 8; b++) begin
                    if (byte_mask[b]) begin
                        mem[idx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rtc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_counter #(
    parameter int CLK_DIV = 4
) (
    input  logic           clk,
    input  logic           rst,
    output bus_pkg::data_t count
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [DIV_W-1:0] pre_q;
    logic             tick;

    // prescaler wraps at CLK_DIV-1
    assign tick = (pre_q == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_q <= '0;
            count <= '0;
        end else begin
            if (tick) begin
                pre_q <= '0;
                count <= count + 64'd1;
            end else begin
                pre_q <= pre_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mmio_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  bus_pkg::bus_req_t  req,
    output logic               req_ready,
    output logic               resp_valid,
    input  logic               resp_ready,
    output logic               access_en,
    output bus_pkg::bus_req_t  cur_req
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } state_e;

    state_e state_q;
    state_e state_d;

    // flow control lives here only
    assign req_ready  = (state_q == IDLE);
    assign access_en  = (state_q == ACCESS);
    assign resp_valid = (state_q == RESP);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid) begin
                    state_d = ACCESS;
                end
            end
            // single access cycle, devices act on access_en
            ACCESS: begin
                state_d = RESP;
            end
            RESP: begin
                if (resp_ready) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // in-flight request, held until the next acceptance
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur_req <= req;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    import bus_pkg::*;

    // decoded target of a request
    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_KBD,
        REGION_SWT,
        REGION_RTC,
        REGION_SEG,
        REGION_LED,
        REGION_SERIAL,
        REGION_NONE
    } region_e;

    // base addresses and lengths in bytes
    parameter addr_t RAM_BASE    = 32'h8000_0000;
    parameter addr_t RAM_LEN     = 32'h0000_1000;
    parameter addr_t KBD_BASE    = 32'hA000_0060;
    parameter addr_t KBD_LEN     = 32'h0000_0008;
    parameter addr_t SWT_BASE    = 32'hA000_0100;
    parameter addr_t SWT_LEN     = 32'h0000_0008;
    parameter addr_t RTC_BASE    = 32'hA000_0048;
    parameter addr_t RTC_LEN     = 32'h0000_0008;
    parameter addr_t SEG_BASE    = 32'hA000_0200;
    parameter addr_t SEG_LEN     = 32'h0000_0008;
    parameter addr_t LED_BASE    = 32'hA000_0208;
    parameter addr_t LED_LEN     = 32'h0000_0008;
    parameter addr_t SERIAL_BASE = 32'hA000_03F8;
    parameter addr_t SERIAL_LEN  = 32'h0000_0008;

    function automatic region_e region_of(addr_t addr);
        region_e region;
        region = REGION_NONE;
        if (addr >= RAM_BASE && addr < RAM_BASE + RAM_LEN) region = REGION_RAM;
        if (addr >= KBD_BASE && addr < KBD_BASE + KBD_LEN) region = REGION_KBD;
        if (addr >= SWT_BASE && addr < SWT_BASE + SWT_LEN) region = REGION_SWT;
        if (addr >= RTC_BASE && addr < RTC_BASE + RTC_LEN) region = REGION_RTC;
        if (addr >= SEG_BASE && addr < SEG_BASE + SEG_LEN) region = REGION_SEG;
        if (addr >= LED_BASE && addr < LED_BASE + LED_LEN) region = REGION_LED;
        if (addr >= SERIAL_BASE && addr < SERIAL_BASE + SERIAL_LEN) region = REGION_SERIAL;
        return region;
    endfunction

endpackage

`default_nettype wire

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // widths that carry a meaning on the bus
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  kb_code_t;
    typedef logic [31:0] seg_t;
    typedef logic [15:0] led_t;

    // access width, applied to writes only
    typedef enum logic [1:0] {
        WIDTH_BYTE,
        WIDTH_HALF,
        WIDTH_WORD,
        WIDTH_DOUBLE
    } width_e;

    // one request from the master
    typedef struct packed {
        logic   write;
        addr_t  addr;
        data_t  wdata;
        width_e width;
    } bus_req_t;

    // response back to the master
    typedef struct packed {
        data_t rdata;
        // unmapped address
        logic  err;
    } bus_resp_t;

endpackage

`default_nettype wire
